//--- vlog.f
verilog/issue_pkg.sv
verilog/id_tracking.sv
verilog/id_table.sv
verilog/completion_tracker.sv
verilog/retire_control.sv
verilog/issue_tracker_top.sv
bench/issue_tracker_assertions.sv
bench/tb_issue_tracker.sv

//--- Makefile
# Verilator build for the issue tracker testbench

VERILATOR ?= verilator
TOP       ?= tb_issue_tracker
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)
PASS_TEXT ?= Result: PASSED

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/tb_issue_tracker.sv
module tb_issue_tracker;
    timeunit 1ns;
    timeprecision 1ps;

    import issue_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_INSTR = 2000;
    localparam int CYCLE_ALLOWANCE = 20;
    localparam int WATCHDOG_NS = NUM_INSTR * CYCLE_ALLOWANCE * CLK_PERIOD;
    localparam int DRAIN_CYCLES = 8 * MAX_INFLIGHT;
    localparam logic [31:0] LFSR_SEED = 32'h8d71_12fa;
    // Taps for x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_POLY = 32'h8020_0003;

    // Reference entry per issued instruction
    typedef struct packed {
        instr_id_t id;
        instr_t instr;
        logic [DATA_W-1:0] data;
        logic written;
    } ref_entry_t;

    logic clk;
    logic rst;
    logic instr_valid;
    instr_t instr;
    logic instr_accept;
    logic issue_valid;
    instr_id_t issue_id;
    instr_t issue_instr;
    logic wb_valid;
    wb_t wb;
    logic retire_valid;
    retire_t retire;

    // Issued instructions in program order
    ref_entry_t ref_q[$];
    // In flight, result not yet sent
    instr_id_t pending[$];
    logic [31:0] lfsr = LFSR_SEED;
    logic was_issued;
    int issued_total = 0;

    issue_tracker_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_accept (instr_accept),
        .issue_valid  (issue_valid),
        .issue_id     (issue_id),
        .issue_instr  (issue_instr),
        .wb_valid     (wb_valid),
        .wb           (wb),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Helpers

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // One Galois step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_POLY) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Oldest issued entry with its result
    function automatic retire_t expected_retire();
        retire_t r;
        r.rd = ref_q[0].instr.rd;
        r.tag = ref_q[0].instr.tag;
        r.data = ref_q[0].data;
        return r;
    endfunction

    // One clock of decode and execution unit activity
    task automatic run_cycle(input bit offer, input bit do_wb);
        int idx;
        @(posedge clk);
        #(DRIVE_DELAY);
        // Decode keeps an offer until it is taken
        if (!(instr_valid && !was_issued)) begin
            instr_valid = offer;
            instr.rd = REG_W'(rand_bits(REG_W));
            instr.tag = TAG_W'(rand_bits(TAG_W));
        end
        wb_valid = 1'b0;
        // Any in-flight ID may complete, out of order
        if (do_wb && pending.size() != 0) begin
            idx = int'(rand_bits(8)) % pending.size();
            wb.id = pending[idx];
            wb.data = rand_bits(DATA_W);
            wb_valid = 1'b1;
            pending.delete(idx);
        end
        @(negedge clk);
        was_issued = issue_valid;
        #1;
    endtask

    task automatic apply_reset(input int cycles);
        @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b1;
        instr_valid = 1'b0;
        wb_valid = 1'b0;
        was_issued = 1'b0;
        repeat (cycles) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;
        @(negedge clk);
        #1;
        check("retire_valid", 64'(retire_valid), 64'(0));
        check("instr_accept", 64'(instr_accept), 64'(1));
    endtask

    // From empty, eight issues and then a stall
    task automatic fill_and_stall();
        for (int c = 0; c < MAX_INFLIGHT + 4; c++) begin
            run_cycle(1'b1, 1'b0);
            check("issue_valid", 64'(issue_valid), 64'(c < MAX_INFLIGHT));
            check("instr_accept", 64'(instr_accept), 64'(c < MAX_INFLIGHT));
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model and compare

    always @(negedge clk) begin
        ref_entry_t entry;
        bit found;
        if (rst !== 1'b0) begin
            ref_q.delete();
            pending.delete();
        end else begin
            if (retire_valid) begin
                if (ref_q.size() == 0 || !ref_q[0].written) begin
                    $display("Retire at %0t without a completed instruction at the head", $time);
                    abort_run();
                end
                check("retire", 64'(retire), 64'(expected_retire()));
                void'(ref_q.pop_front());
            end
            // Accept only below eight in flight
            check("instr_accept", 64'(instr_accept), 64'(ref_q.size() < MAX_INFLIGHT));
            if (wb_valid) begin
                found = 1'b0;
                foreach (ref_q[i]) begin
                    if (ref_q[i].id == wb.id) begin
                        entry = ref_q[i];
                        entry.data = wb.data;
                        entry.written = 1'b1;
                        ref_q[i] = entry;
                        found = 1'b1;
                    end
                end
                if (!found) begin
                    $display("Writeback at %0t to ID %0d which is not in flight", $time, wb.id);
                    abort_run();
                end
            end
            if (issue_valid) begin
                foreach (ref_q[i]) begin
                    if (ref_q[i].id == issue_id) begin
                        $display("ID %0d issued at %0t while still in flight", issue_id, $time);
                        abort_run();
                    end
                end
                check("issue_instr", 64'(issue_instr), 64'(instr));
                entry.id = issue_id;
                entry.instr = instr;
                entry.data = '0;
                entry.written = 1'b0;
                ref_q.push_back(entry);
                pending.push_back(issue_id);
                issued_total++;
            end
        end
    end

    //////////////////////////////////////////////////
    // Watchdog

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        abort_run();
    end

    //////////////////////////////////////////////////
    // Test sequence

    initial begin
        instr_id_t oldest;
        int pos;
        int drain;
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        wb_valid = 1'b0;
        wb = '0;
        was_issued = 1'b0;
        apply_reset(RESET_CYCLES);
        fill_and_stall();

        // Younger results first, nothing may retire
        oldest = ref_q[0].id;
        pos = 0;
        foreach (pending[i]) begin
            if (pending[i] == oldest) pos = i;
        end
        pending.delete(pos);
        repeat (MAX_INFLIGHT - 1) begin
            run_cycle(1'b0, 1'b1);
            check("retire_valid", 64'(retire_valid), 64'(0));
        end
        // Oldest completes, retire two edges later
        pending.push_back(oldest);
        run_cycle(1'b0, 1'b1);
        check("retire_valid", 64'(retire_valid), 64'(0));
        run_cycle(1'b0, 1'b0);
        check("retire_valid", 64'(retire_valid), 64'(0));
        // Then one retire per cycle
        repeat (MAX_INFLIGHT) begin
            run_cycle(1'b0, 1'b0);
            check("retire_valid", 64'(retire_valid), 64'(1));
        end
        run_cycle(1'b0, 1'b0);
        check("retire_valid", 64'(retire_valid), 64'(0));

        // Continuous issue near full occupancy
        repeat (200) run_cycle(1'b1, rand_bits(2) == 0);

        // Random traffic, reset halfway
        while (issued_total < NUM_INSTR / 2) begin
            run_cycle(rand_bits(2) != 0, rand_bits(1) != 0);
        end
        apply_reset(2);
        fill_and_stall();
        while (issued_total < NUM_INSTR) begin
            run_cycle(rand_bits(2) != 0, rand_bits(1) != 0);
        end

        // Complete whatever is left
        drain = 0;
        while ((ref_q.size() != 0 || instr_valid) && drain < DRAIN_CYCLES) begin
            run_cycle(1'b0, 1'b1);
            drain++;
        end

        if (ref_q.size() != 0) begin
            $display("Instructions left in flight after the drain period");
            abort_run();
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

//--- bench/issue_tracker_assertions.sv
module issue_tracker_assertions (
    input logic                                 clk,
    input logic                                 rst,
    input logic                                 issue_valid,
    input logic [issue_pkg::INFLIGHT_CNT_W-1:0] in_use_cnt,
    input logic                                 empty,
    input issue_pkg::instr_id_t                 oldest_id,
    input logic                                 retire_valid,
    input logic                                 wb_valid,
    input issue_pkg::wb_t                       wb,
    input logic [issue_pkg::MAX_INFLIGHT-1:0]   done
);
    timeunit 1ns;
    timeprecision 1ps;

    //////////////////////////////////////////////////
    // Protocol properties

    // No issue while eight are in flight
    assert property (@(posedge clk) disable iff (rst) issue_valid |-> in_use_cnt != '1)
        else $error("issue_valid high while the in-use list is full");

    // Result for the oldest retires two edges later
    assert property (@(posedge clk) disable iff (rst)
        wb_valid && !empty && wb.id == oldest_id |-> ##2 retire_valid)
        else $error("writeback to the oldest ID not retired two cycles later");

    // A result comes back once per issue
    assert property (@(posedge clk) disable iff (rst) wb_valid |-> !done[wb.id])
        else $error("writeback to an ID that is already complete");

endmodule

bind issue_tracker_top issue_tracker_assertions i_assertions (
    .clk          (clk),
    .rst          (rst),
    .issue_valid  (issue_valid),
    .in_use_cnt   (i_id_tracking.in_use_cnt),
    .empty        (empty),
    .oldest_id    (oldest_id),
    .retire_valid (retire_valid),
    .wb_valid     (wb_valid),
    .wb           (wb),
    .done         (i_completion_tracker.done)
);

//--- verilog/issue_tracker_top.sv
module issue_tracker_top (
    input  logic                 clk,
    input  logic                 rst,
    // Decode side
    input  logic                 instr_valid,
    input  issue_pkg::instr_t    instr,
    output logic                 instr_accept,
    output logic                 issue_valid,
    output issue_pkg::instr_id_t issue_id,
    output issue_pkg::instr_t    issue_instr,
    // Writeback side
    input  logic                 wb_valid,
    input  issue_pkg::wb_t       wb,
    // Retire side
    output logic                 retire_valid,
    output issue_pkg::retire_t   retire
);
    import issue_pkg::*;

    //////////////////////////////////////////////////
    // Internal wires

    logic id_available;
    logic empty;
    logic issued;
    logic retired;
    logic oldest_done;
    instr_id_t oldest_id;
    instr_id_t next_id;
    instr_t meta;
    logic [DATA_W-1:0] result;

    // Issue goes out in the same cycle
    assign instr_accept = id_available;
    assign issue_valid = issued;
    assign issue_id = next_id;
    assign issue_instr = instr;

    //////////////////////////////////////////////////
    // Control

    retire_control i_retire_control (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .id_available (id_available),
        .empty        (empty),
        .oldest_done  (oldest_done),
        .meta         (meta),
        .result       (result),
        .issued       (issued),
        .retired      (retired),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    //////////////////////////////////////////////////
    // Datapath

    // Free and in-use ID lists
    id_tracking i_id_tracking (
        .clk          (clk),
        .rst          (rst),
        .issued       (issued),
        .retired      (retired),
        .id_available (id_available),
        .oldest_id    (oldest_id),
        .next_id      (next_id),
        .empty        (empty)
    );

    // Done flags per ID
    completion_tracker i_completion_tracker (
        .clk         (clk),
        .rst         (rst),
        .issued      (issued),
        .issue_id    (next_id),
        .wb_valid    (wb_valid),
        .wb_id       (wb.id),
        .oldest_id   (oldest_id),
        .oldest_done (oldest_done)
    );

    // Destination and tag, written at issue
    id_table #(
        .entry_t (instr_t)
    ) i_meta_table (
        .clk     (clk),
        .wr_en   (issued),
        .wr_id   (next_id),
        .rd_id   (oldest_id),
        .wr_data (instr),
        .rd_data (meta)
    );

    // Results, written at writeback
    id_table #(
        .entry_t (logic [DATA_W-1:0])
    ) i_result_table (
        .clk     (clk),
        .wr_en   (wb_valid),
        .wr_id   (wb.id),
        .rd_id   (oldest_id),
        .wr_data (wb.data),
        .rd_data (result)
    );

endmodule

//--- verilog/retire_control.sv
module retire_control (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         instr_valid,
    input  logic                         id_available,
    input  logic                         empty,
    input  logic                         oldest_done,
    input  issue_pkg::instr_t            meta,
    input  logic [issue_pkg::DATA_W-1:0] result,
    output logic                         issued,
    output logic                         retired,
    output logic                         retire_valid,
    output issue_pkg::retire_t           retire
);
    import issue_pkg::*;

    //////////////////////////////////////////////////
    // Issue and retire decisions

    // Issue whenever decode offers and an ID is free
    assign issued = instr_valid & id_available;

    // Retire the oldest once its result is back
    assign retired = ~empty & oldest_done;

    //////////////////////////////////////////////////
    // Retire outputs

    // Retired entry assembled from both table reads
    retire_t retire_next;

    always_comb begin
        retire_next.rd = meta.rd;
        retire_next.tag = meta.tag;
        retire_next.data = result;
    end

    // Strobe one cycle after the retire decision
    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= retired;
        end
    end

    // Payload captured only on a retire
    always_ff @(posedge clk) begin
        if (retired) begin
            retire <= retire_next;
        end
    end

endmodule

//--- verilog/completion_tracker.sv
module completion_tracker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issued,
    input  issue_pkg::instr_id_t issue_id,
    input  logic                 wb_valid,
    input  issue_pkg::instr_id_t wb_id,
    input  issue_pkg::instr_id_t oldest_id,
    output logic                 oldest_done
);
    import issue_pkg::*;

    //////////////////////////////////////////////////
    // Done bits

    // One flag per ID, set once its result is back
    logic [MAX_INFLIGHT-1:0] done;

    // Issue and writeback never share an ID in a cycle
    // Issued IDs come from the free list
    always_ff @(posedge clk) begin
        if (rst) begin
            done <= '0;
        end else begin
            // Fresh instruction not complete yet
            if (issued) begin
                done[issue_id] <= 1'b0;
            end
            // Result has arrived
            if (wb_valid) begin
                done[wb_id] <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Oldest status

    // Stale set bits of retired IDs are harmless
    // Only the oldest in-flight ID is looked at
    assign oldest_done = done[oldest_id];

endmodule

//--- verilog/id_table.sv
module id_table #(
    parameter type entry_t = issue_pkg::instr_t
) (
    input  logic                 clk,
    input  logic                 wr_en,
    input  issue_pkg::instr_id_t wr_id,
    input  issue_pkg::instr_id_t rd_id,
    input  entry_t               wr_data,
    output entry_t               rd_data
);
    import issue_pkg::*;

    //////////////////////////////////////////////////
    // Entry storage

    // One entry per ID
    entry_t entries [MAX_INFLIGHT];

    //////////////////////////////////////////////////
    // Write port

    // Written on issue or on writeback,
    // depending on the instance
    always_ff @(posedge clk) begin
        if (wr_en) begin
            entries[wr_id] <= wr_data;
        end
    end

    //////////////////////////////////////////////////
    // Read port

    // Asynchronous read at the requested ID
    // Retire logic reads the oldest entry here
    assign rd_data = entries[rd_id];

endmodule

//--- verilog/id_tracking.sv
module id_tracking (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issued,
    input  logic                 retired,
    output logic                 id_available,
    output issue_pkg::instr_id_t oldest_id,
    output issue_pkg::instr_id_t next_id,
    output logic                 empty
);
    import issue_pkg::*;

    //////////////////////////////////////////////////
    // Storage

    // Index counters, top bit marks valid entries
    logic [INFLIGHT_CNT_W-1:0] in_use_cnt;
    logic [INFLIGHT_CNT_W-1:0] free_cnt;

    // Shift-register FIFOs, newest entry at index 0
    instr_id_t in_use_ids [MAX_INFLIGHT];
    instr_id_t free_ids [MAX_INFLIGHT];

    //////////////////////////////////////////////////
    // Free list contents

    // Every ID starts out free
    initial begin
        for (int i = 0; i < MAX_INFLIGHT; i++) begin
            free_ids[i] = instr_id_t'(i);
        end
    end

    // Retired IDs go back in at the bottom
    always_ff @(posedge clk) begin
        if (retired) begin
            free_ids[0] <= oldest_id;
            for (int i = 1; i < MAX_INFLIGHT; i++) begin
                free_ids[i] <= free_ids[i-1];
            end
        end
    end

    //////////////////////////////////////////////////
    // In-use list contents

    // Issued ID enters at the bottom
    always_ff @(posedge clk) begin
        if (issued) begin
            in_use_ids[0] <= next_id;
            for (int i = 1; i < MAX_INFLIGHT; i++) begin
                in_use_ids[i] <= in_use_ids[i-1];
            end
        end
    end

    //////////////////////////////////////////////////
    // Index counters

    // Empty list sits at 0_111, first push rolls to 1_000
    always_ff @(posedge clk) begin
        if (rst) begin
            in_use_cnt <= {1'b0, {ID_W{1'b1}}};
        end else begin
            in_use_cnt <= in_use_cnt + INFLIGHT_CNT_W'(issued)
                        - INFLIGHT_CNT_W'(retired);
        end
    end

    // Free list starts full at 1_111
    always_ff @(posedge clk) begin
        if (rst) begin
            free_cnt <= '1;
        end else begin
            free_cnt <= free_cnt + INFLIGHT_CNT_W'(retired)
                      - INFLIGHT_CNT_W'(issued);
        end
    end

    // Status from the top counter bits
    assign empty = ~in_use_cnt[INFLIGHT_CNT_W-1];
    assign id_available = free_cnt[INFLIGHT_CNT_W-1];

    // Oldest entry of each FIFO
    assign next_id = free_ids[free_cnt[ID_W-1:0]];
    assign oldest_id = in_use_ids[in_use_cnt[ID_W-1:0]];

endmodule

//--- verilog/issue_pkg.sv
package issue_pkg;

    //////////////////////////////////////////////////
    // Sizing

    // Instructions in flight at once
    localparam int MAX_INFLIGHT = 8;

    // ID width and FIFO index width
    localparam int ID_W = $clog2(MAX_INFLIGHT);
    // Extra top bit acts as the valid flag
    localparam int INFLIGHT_CNT_W = ID_W + 1;

    // Payload widths
    localparam int REG_W = 5;
    localparam int TAG_W = 16;
    localparam int DATA_W = 32;

    //////////////////////////////////////////////////
    // Types

    typedef logic [ID_W-1:0] instr_id_t;

    // Decoded instruction, also the metadata table entry
    typedef struct packed {
        logic [REG_W-1:0] rd;
        logic [TAG_W-1:0] tag;
    } instr_t;

    // Result from an execution unit
    typedef struct packed {
        instr_id_t id;
        logic [DATA_W-1:0] data;
    } wb_t;

    // Retired instruction with its result
    typedef struct packed {
        logic [REG_W-1:0] rd;
        logic [TAG_W-1:0] tag;
        logic [DATA_W-1:0] data;
    } retire_t;

endpackage
